// File: src.f
+incdir+verif
rtl/cmt_pkg.sv
rtl/cmt_head_if.sv
rtl/cmt_select.sv
rtl/cmt_serial.sv
rtl/cmt_top.sv
verif/tb_cmt.sv

// File: Makefile
# Verilator build and run of the commit stage testbench.
# Override any variable on the command line, for example make run TOP=tb_cmt

VERILATOR ?= verilator
TOP       ?= tb_cmt
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/tb_cmt_tasks.svh
// Directed test tasks for the commit stage testbench.
// Included inside tb_cmt, so the tasks drive and sample its signals
// directly. Expected values follow the commit rules: in-order prefix,
// slot-0 serialization, long-operation wait and the flush merge.

`ifndef TB_CMT_TASKS_SVH
`define TB_CMT_TASKS_SVH

task automatic next_cycle();
   @(posedge clk);
   #2;                                                  // Drive just after the edge
endtask

task automatic settle();
   @(negedge clk);                                      // Outputs stable here
endtask

task automatic note_mismatch(input string test, input string detail);
   $display("mismatch %s: %s", test, detail);
   errors++;
endtask

function automatic logic [31:0] random_word();
   return $random(seed);
endfunction

function automatic cmt_pkg::pc_t random_pc();
   logic [31:0] w;
   w = random_word();
   return w[cmt_pkg::PC_W-1:0];
endfunction

// Valid slots from slot 0 up to the first gap
function automatic logic [3:0] leading_run(input logic [3:0] v);
   logic [3:0] r;
   logic       open;
   open = 1'b1;
   for (int i = 0; i < 4; i++)
   begin
      open = open & v[i];
      r[i] = open;
   end
   return r;
endfunction

function automatic logic [2:0] count_ones(input logic [3:0] v);
   logic [2:0] n;
   n = '0;
   for (int i = 0; i < 4; i++)
   begin
      if (v[i])
         n = n + 3'd1;
   end
   return n;
endfunction

task automatic clear_inputs();
   for (int i = 0; i < cmt_pkg::CW; i++)
   begin
      cmt_lsu_opc[i] = cmt_pkg::LSU_NONE;
      cmt_epu_opc[i] = cmt_pkg::EPU_NONE;
      cmt_pc[i]      = cmt_pkg::pc_t'(64 + i);
   end
   cmt_valid     = '0;
   cmt_exc       = '0;
   cmt_fls       = '0;
   cmt_is_bcc    = '0;
   cmt_is_brel   = '0;
   cmt_is_breg   = '0;
   cmt_fls_tgt   = '0;
   cmt_bpu_upd   = '0;
   cmt_prd_we    = 1'b0;
   cmt_prd       = '0;
   lsu_wb_valid  = 1'b0;
   lsu_wb_dout   = '0;
   epu_wb_valid  = 1'b0;
   epu_wb_dout   = '0;
   exc_flush     = 1'b0;
   exc_flush_tgt = '0;
   refetch       = 1'b0;
endtask

task automatic mark_special(input int slot, input int kind);
   case (kind)
      0: cmt_lsu_opc[slot] = cmt_pkg::LSU_SW;
      1: cmt_epu_opc[slot] = cmt_pkg::EPU_RMSR;
      2: cmt_exc[slot]     = 1'b1;
      3: cmt_fls[slot]     = 1'b1;
      4: cmt_is_bcc[slot]  = 1'b1;
      5: cmt_is_brel[slot] = 1'b1;
      default: cmt_is_breg[slot] = 1'b1;
   endcase
endtask

task automatic check_reset_state();
   settle();
   if ({flush, lsu_req, epu_req, prf_we, bpu_wb} !== 5'b00000)
      note_mismatch("reset",
                    $sformatf("flush/lsu_req/epu_req/prf_we/bpu_wb expected 00000, actual %b",
                              {flush, lsu_req, epu_req, prf_we, bpu_wb}));
endtask

task automatic check_fire(input string name, input logic [3:0] exp_fire);
   if (cmt_fire !== exp_fire)
      note_mismatch(name, $sformatf("cmt_fire expected %b, actual %b", exp_fire, cmt_fire));
   if (cmt_pop_size !== count_ones(exp_fire))
      note_mismatch(name, $sformatf("cmt_pop_size expected %0d, actual %0d",
                    count_ones(exp_fire), cmt_pop_size));
endtask

task automatic plain_multi_commit();
   logic [31:0] rnd;
   for (int n = 0; n < 20; n++)
   begin
      next_cycle();
      clear_inputs();
      rnd       = random_word();
      cmt_valid = rnd[3:0];
      settle();
      check_fire("plain_commit", leading_run(rnd[3:0]));
   end
endtask

// Slot 0 only gets branches here, its other kinds start a long op or a flush
task automatic serialize_special();
   logic [31:0] rnd;
   int          below;
   for (int slot = 0; slot < cmt_pkg::CW; slot++)
   begin
      for (int kind = 0; kind < 7; kind++)
      begin
         if (slot > 0 || kind >= 4)
         begin
            next_cycle();
            clear_inputs();
            rnd       = random_word();
            cmt_valid = rnd[3:0];
            mark_special(slot, kind);
            below     = (slot == 0) ? 1 : (1 << slot) - 1;   // Group ends at the special one
            settle();
            check_fire("serialize", leading_run(rnd[3:0]) & below[3:0]);
         end
      end
   end
endtask

task automatic long_op_handshake(input logic use_epu);
   string       name;
   logic [31:0] rnd;
   logic [31:0] dout;
   int          wait_n;
   int          pulses;
   name   = use_epu ? "epu_op" : "lsu_op";
   pulses = 0;
   next_cycle();
   clear_inputs();
   cmt_valid = 4'b0111;
   if (use_epu)
      cmt_epu_opc[0] = cmt_pkg::EPU_SYSCALL;
   else
      cmt_lsu_opc[0] = cmt_pkg::LSU_LW;
   rnd        = random_word();
   cmt_prd    = rnd[cmt_pkg::PRF_AW-1:0];
   cmt_prd_we = ~use_epu;                               // Loads write a register, syscalls not
   rnd        = random_word();
   wait_n     = 1 + int'(rnd % 5);
   // Request cycle, then the unit stays busy for wait_n cycles
   for (int c = 0; c <= wait_n; c++)
   begin
      if (c > 0)
         next_cycle();
      settle();
      pulses += int'(use_epu ? epu_req : lsu_req);
      check_fire(name, 4'b0000);
   end
   next_cycle();
   dout         = random_word();
   lsu_wb_valid = ~use_epu;
   epu_wb_valid = use_epu;
   lsu_wb_dout  = use_epu ? ~dout : dout;               // Other unit carries a decoy
   epu_wb_dout  = use_epu ? dout : ~dout;
   settle();
   pulses += int'(use_epu ? epu_req : lsu_req);
   check_fire(name, 4'b0001);
   if (pulses != 1)
      note_mismatch(name, $sformatf("request pulses expected 1, actual %0d", pulses));
   if (prf_we !== cmt_prd_we)
      note_mismatch(name, $sformatf("prf_we expected %b, actual %b", cmt_prd_we, prf_we));
   if (prf_waddr !== cmt_prd)
      note_mismatch(name, $sformatf("prf_waddr expected %h, actual %h", cmt_prd, prf_waddr));
   if (prf_wdata !== dout)
      note_mismatch(name, $sformatf("prf_wdata expected %h, actual %h", dout, prf_wdata));
   next_cycle();
   clear_inputs();
endtask

task automatic self_flush_restart(input logic use_refetch);
   string        name;
   cmt_pkg::pc_t exp_tgt;
   name = use_refetch ? "refetch" : "self_flush";
   next_cycle();
   clear_inputs();
   cmt_valid   = 4'b0001;
   cmt_pc[0]   = random_pc();
   cmt_fls_tgt = random_pc();
   if (use_refetch)
   begin
      refetch = 1'b1;
      exp_tgt = cmt_pc[0] + cmt_pkg::pc_t'(1);          // Restart after slot 0
   end
   else
   begin
      cmt_fls[0] = 1'b1;
      exp_tgt    = cmt_fls_tgt;
   end
   settle();
   check_fire(name, 4'b0001);
   next_cycle();
   clear_inputs();
   cmt_valid = 4'b1111;                                 // Younger work held by the flush
   settle();
   if (flush !== 1'b1)
      note_mismatch(name, $sformatf("flush expected 1, actual %b", flush));
   if (flush_tgt !== exp_tgt)
      note_mismatch(name, $sformatf("flush_tgt expected %h, actual %h", exp_tgt, flush_tgt));
   check_fire(name, 4'b0000);
   next_cycle();
   clear_inputs();
   settle();
   if (flush !== 1'b0)
      note_mismatch(name, $sformatf("flush one cycle later expected 0, actual %b", flush));
endtask

task automatic exception_flush();
   cmt_pkg::pc_t tgt;
   next_cycle();
   clear_inputs();
   cmt_valid      = 4'b0001;
   cmt_lsu_opc[0] = cmt_pkg::LSU_SB;
   cmt_prd_we     = 1'b1;
   next_cycle();
   next_cycle();
   tgt           = random_pc();
   exc_flush     = 1'b1;
   exc_flush_tgt = tgt;
   lsu_wb_valid  = 1'b1;                                // Done lands on the flush
   settle();
   if ({flush, prf_we} !== 2'b10)
      note_mismatch("exc_flush", $sformatf("flush/prf_we expected 10, actual %b",
                    {flush, prf_we}));
   if (flush_tgt !== tgt)
      note_mismatch("exc_flush", $sformatf("flush_tgt expected %h, actual %h", tgt, flush_tgt));
   check_fire("exc_flush", 4'b0000);
   next_cycle();
   clear_inputs();
   settle();
   if (flush !== 1'b0)
      note_mismatch("exc_flush", $sformatf("flush after release expected 0, actual %b", flush));
endtask

task automatic branch_update();
   logic [31:0]  rnd;
   logic [4:0]   exp_bits;
   cmt_pkg::pc_t exp_npc;
   for (int n = 0; n < 9; n++)
   begin
      next_cycle();
      clear_inputs();
      rnd               = random_word();
      cmt_valid         = rnd[3:0] | 4'b0001;
      cmt_is_bcc[0]     = (n % 3 == 0);
      cmt_is_brel[0]    = (n % 3 == 1);
      cmt_is_breg[0]    = (n % 3 == 2);
      cmt_fls[0]        = rnd[4];                       // Mispredicted
      cmt_bpu_upd.taken = rnd[5];
      cmt_bpu_upd.tgt   = random_pc();
      cmt_fls_tgt       = random_pc();
      cmt_pc[0]         = random_pc();
      exp_bits = {1'b1, cmt_is_bcc[0], cmt_is_brel[0], cmt_is_breg[0], rnd[5] ^ rnd[4]};
      exp_npc  = rnd[4] ? cmt_fls_tgt : cmt_bpu_upd.tgt;
      settle();
      check_fire("branch", 4'b0001);
      if ({bpu_wb, bpu_wb_is_bcc, bpu_wb_is_brel, bpu_wb_is_breg, bpu_wb_taken} !== exp_bits)
         note_mismatch("branch", $sformatf("wb/bcc/brel/breg/taken expected %b, actual %b",
                       exp_bits, {bpu_wb, bpu_wb_is_bcc, bpu_wb_is_brel, bpu_wb_is_breg,
                       bpu_wb_taken}));
      if (bpu_wb_npc_act !== exp_npc)
         note_mismatch("branch", $sformatf("bpu_wb_npc_act expected %h, actual %h",
                       exp_npc, bpu_wb_npc_act));
      if (bpu_wb_pc !== cmt_pc[0])
         note_mismatch("branch", $sformatf("bpu_wb_pc expected %h, actual %h",
                       cmt_pc[0], bpu_wb_pc));
      if (bpu_wb_upd !== cmt_bpu_upd)
         note_mismatch("branch", $sformatf("bpu_wb_upd expected %h, actual %h",
                       cmt_bpu_upd, bpu_wb_upd));
      next_cycle();
      clear_inputs();
      settle();
      if (flush !== rnd[4])
         note_mismatch("branch", $sformatf("flush expected %b, actual %b", rnd[4], flush));
   end
endtask

`endif

// File: verif/tb_cmt.sv
// Directed testbench for the commit stage.
// Drives the ROB head slots and the unit strobes of cmt_top, checks the
// fire vector, pop count, flush, writeback and predictor update, and ends
// with the error count. The test tasks come from the included header.

`timescale 1ns/10ps

module tb_cmt;

   logic                                    clk;
   logic                                    rst_n;
   logic [cmt_pkg::CW-1:0]                  cmt_valid;
   cmt_pkg::lsu_opc_t [cmt_pkg::CW-1:0]     cmt_lsu_opc;
   cmt_pkg::epu_opc_t [cmt_pkg::CW-1:0]     cmt_epu_opc;
   logic [cmt_pkg::CW-1:0]                  cmt_exc;
   logic [cmt_pkg::CW-1:0]                  cmt_fls;
   logic [cmt_pkg::CW-1:0]                  cmt_is_bcc;
   logic [cmt_pkg::CW-1:0]                  cmt_is_brel;
   logic [cmt_pkg::CW-1:0]                  cmt_is_breg;
   cmt_pkg::pc_t [cmt_pkg::CW-1:0]          cmt_pc;
   cmt_pkg::pc_t                            cmt_fls_tgt;
   cmt_pkg::bpu_upd_t                       cmt_bpu_upd;
   logic                                    cmt_prd_we;
   logic [cmt_pkg::PRF_AW-1:0]              cmt_prd;
   logic                                    lsu_wb_valid;
   logic [cmt_pkg::DW-1:0]                  lsu_wb_dout;
   logic                                    epu_wb_valid;
   logic [cmt_pkg::DW-1:0]                  epu_wb_dout;
   logic                                    exc_flush;
   cmt_pkg::pc_t                            exc_flush_tgt;
   logic                                    refetch;
   logic [cmt_pkg::CW-1:0]                  cmt_fire;
   logic [cmt_pkg::P_COMMIT_WIDTH:0]        cmt_pop_size;
   logic                                    bpu_wb;
   logic                                    bpu_wb_is_bcc;
   logic                                    bpu_wb_is_brel;
   logic                                    bpu_wb_is_breg;
   logic                                    bpu_wb_taken;
   cmt_pkg::pc_t                            bpu_wb_pc;
   cmt_pkg::pc_t                            bpu_wb_npc_act;
   cmt_pkg::bpu_upd_t                       bpu_wb_upd;
   logic                                    lsu_req;
   logic                                    epu_req;
   logic                                    flush;
   cmt_pkg::pc_t                            flush_tgt;
   logic                                    prf_we;
   logic [cmt_pkg::PRF_AW-1:0]              prf_waddr;
   logic [cmt_pkg::DW-1:0]                  prf_wdata;

   integer seed       = 37608;
   int     errors     = 0;
   int     cycles     = 0;
   int     max_cycles = 2000;                          // Tests need about 120 cycles

   cmt_top i_dut (.*);

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;                          // 40 ns period
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= max_cycles)
      begin
         $display("Timeout: run stopped after %0d cycles", cycles);
         $display("Errors found");
         $finish;
      end
   end

   `include "tb_cmt_tasks.svh"

   initial
   begin
      clear_inputs();
      rst_n = 1'b0;
      repeat (8) @(posedge clk);
      #2 rst_n = 1'b1;
      check_reset_state();
      plain_multi_commit();
      serialize_special();
      long_op_handshake(1'b0);
      long_op_handshake(1'b1);
      self_flush_restart(1'b0);
      self_flush_restart(1'b1);
      exception_flush();
      branch_update();
      repeat (2) next_cycle();
      $display("Run complete: %0d errors after %0d cycles", errors, cycles);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

// File: rtl/cmt_top.sv
// Commit stage top level.
// Connects the slot selector and the long-operation serializer through
// the slot-0 head interface. The load/store and exception units sit
// outside and talk to this block through request pulses, done strobes
// and the exception flush.

`timescale 1ns/10ps

module cmt_top
(
   input  logic                                    clk,
   input  logic                                    rst_n,
   // From ROB head
   input  logic [cmt_pkg::CW-1:0]                  cmt_valid,
   input  cmt_pkg::lsu_opc_t [cmt_pkg::CW-1:0]     cmt_lsu_opc,
   input  cmt_pkg::epu_opc_t [cmt_pkg::CW-1:0]     cmt_epu_opc,
   input  logic [cmt_pkg::CW-1:0]                  cmt_exc,
   input  logic [cmt_pkg::CW-1:0]                  cmt_fls,
   input  logic [cmt_pkg::CW-1:0]                  cmt_is_bcc,
   input  logic [cmt_pkg::CW-1:0]                  cmt_is_brel,
   input  logic [cmt_pkg::CW-1:0]                  cmt_is_breg,
   input  cmt_pkg::pc_t [cmt_pkg::CW-1:0]          cmt_pc,
   input  cmt_pkg::pc_t                            cmt_fls_tgt,
   input  cmt_pkg::bpu_upd_t                       cmt_bpu_upd,
   input  logic                                    cmt_prd_we,
   input  logic [cmt_pkg::PRF_AW-1:0]              cmt_prd,
   // From LSU and EPU
   input  logic                                    lsu_wb_valid,
   input  logic [cmt_pkg::DW-1:0]                  lsu_wb_dout,
   input  logic                                    epu_wb_valid,
   input  logic [cmt_pkg::DW-1:0]                  epu_wb_dout,
   input  logic                                    exc_flush,
   input  cmt_pkg::pc_t                            exc_flush_tgt,
   input  logic                                    refetch,
   // To ROB
   output logic [cmt_pkg::CW-1:0]                  cmt_fire,
   output logic [cmt_pkg::P_COMMIT_WIDTH:0]        cmt_pop_size,
   // To BPU
   output logic                                    bpu_wb,
   output logic                                    bpu_wb_is_bcc,
   output logic                                    bpu_wb_is_brel,
   output logic                                    bpu_wb_is_breg,
   output logic                                    bpu_wb_taken,
   output cmt_pkg::pc_t                            bpu_wb_pc,
   output cmt_pkg::pc_t                            bpu_wb_npc_act,
   output cmt_pkg::bpu_upd_t                       bpu_wb_upd,
   // To LSU and EPU
   output logic                                    lsu_req,
   output logic                                    epu_req,
   // To frontend and PRF
   output logic                                    flush,
   output cmt_pkg::pc_t                            flush_tgt,
   output logic                                    prf_we,
   output logic [cmt_pkg::PRF_AW-1:0]              prf_waddr,
   output logic [cmt_pkg::DW-1:0]                  prf_wdata
);

   cmt_head_if head (.clk(clk));

   cmt_select i_select
   (
      .cmt_valid      (cmt_valid),
      .cmt_lsu_opc    (cmt_lsu_opc),
      .cmt_epu_opc    (cmt_epu_opc),
      .cmt_exc        (cmt_exc),
      .cmt_fls        (cmt_fls),
      .cmt_is_bcc     (cmt_is_bcc),
      .cmt_is_brel    (cmt_is_brel),
      .cmt_is_breg    (cmt_is_breg),
      .cmt_pc         (cmt_pc),
      .cmt_fls_tgt    (cmt_fls_tgt),
      .cmt_bpu_upd    (cmt_bpu_upd),
      .head           (head.select),
      .cmt_fire       (cmt_fire),
      .cmt_pop_size   (cmt_pop_size),
      .bpu_wb         (bpu_wb),
      .bpu_wb_is_bcc  (bpu_wb_is_bcc),
      .bpu_wb_is_brel (bpu_wb_is_brel),
      .bpu_wb_is_breg (bpu_wb_is_breg),
      .bpu_wb_taken   (bpu_wb_taken),
      .bpu_wb_pc      (bpu_wb_pc),
      .bpu_wb_npc_act (bpu_wb_npc_act),
      .bpu_wb_upd     (bpu_wb_upd)
   );

   cmt_serial i_serial
   (
      .clk            (clk),
      .rst_n          (rst_n),
      .cmt_pc0        (cmt_pc[0]),
      .cmt_fls0       (cmt_fls[0]),
      .cmt_fls_tgt0   (cmt_fls_tgt),
      .cmt_prd_we     (cmt_prd_we),
      .cmt_prd        (cmt_prd),
      .lsu_wb_valid   (lsu_wb_valid),
      .lsu_wb_dout    (lsu_wb_dout),
      .epu_wb_valid   (epu_wb_valid),
      .epu_wb_dout    (epu_wb_dout),
      .exc_flush      (exc_flush),
      .exc_flush_tgt  (exc_flush_tgt),
      .refetch        (refetch),
      .head           (head.serial),
      .lsu_req        (lsu_req),
      .epu_req        (epu_req),
      .flush          (flush),
      .flush_tgt      (flush_tgt),
      .prf_we         (prf_we),
      .prf_waddr      (prf_waddr),
      .prf_wdata      (prf_wdata)
   );

endmodule

// File: rtl/cmt_serial.sv
// Serializer for long slot-0 operations and flush control.
// Hands a slot-0 load/store or exception operation to its unit, stalls
// commit until the unit's done strobe and writes the result back to the
// register file. Holds the one-cycle self-flush raised by a mispredict or
// a refetch and merges it with the exception flush, self-flush first.

`timescale 1ns/10ps

module cmt_serial
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  cmt_pkg::pc_t                cmt_pc0,
   input  logic                        cmt_fls0,
   input  cmt_pkg::pc_t                cmt_fls_tgt0,
   input  logic                        cmt_prd_we,
   input  logic [cmt_pkg::PRF_AW-1:0]  cmt_prd,
   input  logic                        lsu_wb_valid,
   input  logic [cmt_pkg::DW-1:0]      lsu_wb_dout,
   input  logic                        epu_wb_valid,
   input  logic [cmt_pkg::DW-1:0]      epu_wb_dout,
   input  logic                        exc_flush,
   input  cmt_pkg::pc_t                exc_flush_tgt,
   input  logic                        refetch,
   cmt_head_if.serial                  head,
   output logic                        lsu_req,
   output logic                        epu_req,
   output logic                        flush,
   output cmt_pkg::pc_t                flush_tgt,
   output logic                        prf_we,
   output logic [cmt_pkg::PRF_AW-1:0]  prf_waddr,
   output logic [cmt_pkg::DW-1:0]      prf_wdata
);

   cmt_pkg::cmt_state_t state_q;
   cmt_pkg::cmt_state_t state_nxt;
   logic                pipe_req;
   logic                pipe_finish;
   logic                se_fls_q;
   logic                se_fls_nxt;
   cmt_pkg::pc_t        se_tgt_q;
   cmt_pkg::pc_t        se_tgt_nxt;
   cmt_pkg::pc_t        npc0;

   assign pipe_req    = head.ready0 & (head.lsu_req0 | head.epu_req0);
   assign pipe_finish = lsu_wb_valid | epu_wb_valid;

   // Request only on entry, the unit then owns slot 0 until done
   assign lsu_req = (state_q == cmt_pkg::S_IDLE) & head.ready0 & head.lsu_req0;
   assign epu_req = (state_q == cmt_pkg::S_IDLE) & head.ready0 & head.epu_req0;

   assign head.cmt_ce = ~pipe_req | pipe_finish;

   always_comb
   begin
      state_nxt = state_q;
      case (state_q)
         cmt_pkg::S_IDLE:
         begin
            if (pipe_req)
               state_nxt = cmt_pkg::S_PENDING;
         end
         cmt_pkg::S_PENDING:
         begin
            if (pipe_finish)
               state_nxt = cmt_pkg::S_IDLE;
         end
         default:
            state_nxt = cmt_pkg::S_IDLE;                 // Recover from a bad encoding
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state_q <= cmt_pkg::S_IDLE;
      else
         state_q <= state_nxt;
   end

   assign npc0 = cmt_pc0 + {{(cmt_pkg::PC_W-1){1'b0}}, 1'b1};

   // Self-clearing: a set bit always loads zero on the next edge
   assign se_fls_nxt = (cmt_fls0 | refetch) & ~se_fls_q;
   assign se_tgt_nxt = cmt_fls0 ? cmt_fls_tgt0 : npc0;   // Refetch restarts at pc+1

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         se_fls_q <= 1'b0;
      else if (head.fire0 | se_fls_q)
         se_fls_q <= se_fls_nxt;
   end

   always_ff @(posedge clk)
   begin
      if (head.fire0)
         se_tgt_q <= se_tgt_nxt;
   end

   assign flush       = se_fls_q | exc_flush;
   assign flush_tgt   = se_fls_q ? se_tgt_q : exc_flush_tgt;
   assign head.flush  = flush;
   assign head.se_fls = se_fls_q;

   // Long op result goes straight to the PRF in the done cycle
   assign prf_we    = pipe_finish & ~flush & cmt_prd_we;
   assign prf_waddr = cmt_prd;
   assign prf_wdata = epu_wb_valid ? epu_wb_dout : lsu_wb_dout;

   // Units answer one cycle after the request at the earliest
   a_no_done_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
      (state_q == cmt_pkg::S_IDLE) |-> !pipe_finish)
      else $error("cmt_serial: done strobe without a pending request");

   a_no_fire_on_flush: assert property (@(posedge clk) disable iff (!rst_n)
      flush |-> !head.fire0)
      else $error("cmt_serial: slot 0 fired during a flush");

endmodule

// File: rtl/cmt_select.sv
// Commit slot selection.
// Classifies the four ROB head slots, lets ordinary instructions retire
// together as an in-order prefix and forces special ones to retire alone
// in slot 0. Also produces the ROB pop count and the branch-predictor
// update for a retiring slot-0 branch. Purely combinational apart from
// the checks, which sample on the interface clock.

`timescale 1ns/10ps

module cmt_select
(
   input  logic [cmt_pkg::CW-1:0]                  cmt_valid,
   input  cmt_pkg::lsu_opc_t [cmt_pkg::CW-1:0]     cmt_lsu_opc,
   input  cmt_pkg::epu_opc_t [cmt_pkg::CW-1:0]     cmt_epu_opc,
   input  logic [cmt_pkg::CW-1:0]                  cmt_exc,
   input  logic [cmt_pkg::CW-1:0]                  cmt_fls,
   input  logic [cmt_pkg::CW-1:0]                  cmt_is_bcc,
   input  logic [cmt_pkg::CW-1:0]                  cmt_is_brel,
   input  logic [cmt_pkg::CW-1:0]                  cmt_is_breg,
   input  cmt_pkg::pc_t [cmt_pkg::CW-1:0]          cmt_pc,
   input  cmt_pkg::pc_t                            cmt_fls_tgt,   // Slot 0 only
   input  cmt_pkg::bpu_upd_t                       cmt_bpu_upd,   // Slot 0 only
   cmt_head_if.select                              head,
   // To ROB
   output logic [cmt_pkg::CW-1:0]                  cmt_fire,
   output logic [cmt_pkg::P_COMMIT_WIDTH:0]        cmt_pop_size,
   // To BPU
   output logic                                    bpu_wb,
   output logic                                    bpu_wb_is_bcc,
   output logic                                    bpu_wb_is_brel,
   output logic                                    bpu_wb_is_breg,
   output logic                                    bpu_wb_taken,
   output cmt_pkg::pc_t                            bpu_wb_pc,
   output cmt_pkg::pc_t                            bpu_wb_npc_act,
   output cmt_pkg::bpu_upd_t                       bpu_wb_upd
);

   logic [cmt_pkg::CW-1:0] has_lsu;
   logic [cmt_pkg::CW-1:0] has_epu;
   logic [cmt_pkg::CW-1:0] is_br;
   logic [cmt_pkg::CW-1:0] special;
   logic [cmt_pkg::CW-1:0] cmt_mask;
   logic [cmt_pkg::CW-1:0] ready;
   logic [cmt_pkg::CW-1:0] fire_inc;

   always_comb
   begin
      for (int i = 0; i < cmt_pkg::CW; i++)
      begin
         has_lsu[i] = (cmt_lsu_opc[i] != cmt_pkg::LSU_NONE);
         has_epu[i] = (cmt_epu_opc[i] != cmt_pkg::EPU_NONE) | cmt_exc[i];
         is_br[i]   = cmt_is_bcc[i] | cmt_is_brel[i] | cmt_is_breg[i];
      end
   end

   assign special = has_lsu | has_epu | cmt_fls | is_br;

   // A special slot 0 closes the group, a special slot n>0 waits for slot 0
   always_comb
   begin
      cmt_mask[0] = 1'b1;
      cmt_mask[1] = ~special[0] & ~special[1];
      for (int j = 2; j < cmt_pkg::CW; j++)
      begin
         cmt_mask[j] = cmt_mask[j-1] & ~special[j];
      end
   end

   // The group also ends at the first invalid slot
   always_comb
   begin
      ready[0] = cmt_valid[0] & cmt_mask[0];
      for (int m = 1; m < cmt_pkg::CW; m++)
      begin
         ready[m] = ready[m-1] & cmt_valid[m] & cmt_mask[m];
      end
   end

   assign cmt_fire = ready & {cmt_pkg::CW{head.cmt_ce & ~head.flush}};

   always_comb
   begin
      cmt_pop_size = '0;
      for (int k = 0; k < cmt_pkg::CW; k++)
      begin
         cmt_pop_size = cmt_pop_size + {{cmt_pkg::P_COMMIT_WIDTH{1'b0}}, cmt_fire[k]};
      end
   end

   // Pending self-flush kills the instruction, so no unit request
   assign head.lsu_req0 = ~head.se_fls & has_lsu[0];
   assign head.epu_req0 = ~head.se_fls & has_epu[0];
   assign head.ready0   = ready[0];
   assign head.fire0    = cmt_fire[0];

   // Only slot 0 can hold a branch that retires
   assign bpu_wb         = cmt_fire[0] & is_br[0];
   assign bpu_wb_is_bcc  = cmt_is_bcc[0];
   assign bpu_wb_is_brel = cmt_is_brel[0];
   assign bpu_wb_is_breg = cmt_is_breg[0];
   assign bpu_wb_taken   = cmt_bpu_upd.taken ^ cmt_fls[0];     // Mispredict flips direction
   assign bpu_wb_pc      = cmt_pc[0];
   assign bpu_wb_npc_act = cmt_fls[0] ? cmt_fls_tgt : cmt_bpu_upd.tgt;
   assign bpu_wb_upd     = cmt_bpu_upd;

   assign fire_inc = cmt_fire + {{(cmt_pkg::CW-1){1'b0}}, 1'b1};

   a_fire_in_valid: assert property (@(posedge head.clk) (cmt_fire & ~cmt_valid) == '0)
      else $error("cmt_select: fire %b outside valid %b", cmt_fire, cmt_valid);

   // Fired slots must form 2^n-1, so the ROB can pop from the head
   a_fire_prefix: assert property (@(posedge head.clk) (cmt_fire & fire_inc) == '0)
      else $error("cmt_select: fire %b not a prefix from slot 0", cmt_fire);

endmodule

// File: rtl/cmt_head_if.sv
// Slot-0 handshake between the commit selector and the serializer.
// The selector reports what slot 0 needs and whether it fires; the
// serializer answers with the commit enable and the flush state.

`timescale 1ns/10ps

interface cmt_head_if (input logic clk);

   logic lsu_req0;                                      // Slot 0 needs the LSU
   logic epu_req0;                                      // Slot 0 needs the EPU or traps
   logic ready0;                                        // Slot 0 valid and unmasked
   logic fire0;                                         // Slot 0 commits this cycle
   logic cmt_ce;
   logic flush;                                         // Self-flush or exception flush
   logic se_fls;                                        // Registered self-flush only

   modport select (
      input  clk,
      input  cmt_ce,
      input  flush,
      input  se_fls,
      output lsu_req0,
      output epu_req0,
      output ready0,
      output fire0
   );

   modport serial (
      input  lsu_req0,
      input  epu_req0,
      input  ready0,
      input  fire0,
      output cmt_ce,
      output flush,
      output se_fls
   );

endinterface

// File: rtl/cmt_pkg.sv
// Shared definitions for the commit stage.
// Holds the commit width, the datapath widths, the opcode and state
// enums, and the branch-predictor update record that travels with slot 0.
// Every RTL file and the testbench refer to these by scoped name.

package cmt_pkg;

   localparam int P_COMMIT_WIDTH = 2;                   // log2 of the commit width
   localparam int CW             = 1 << P_COMMIT_WIDTH; // Commit slots per cycle
   localparam int PC_W           = 30;                  // Word-addressed PC
   localparam int DW             = 32;
   localparam int PRF_AW         = 6;                   // Physical register index
   localparam int LSU_OPC_W      = 3;
   localparam int EPU_OPC_W      = 3;

   typedef logic [PC_W-1:0] pc_t;

   // Zero means the slot has no work for that unit
   typedef enum logic [LSU_OPC_W-1:0] {
      LSU_NONE = 3'd0,
      LSU_LB   = 3'd1,
      LSU_LW   = 3'd2,
      LSU_SB   = 3'd3,
      LSU_SW   = 3'd4
   } lsu_opc_t;

   typedef enum logic [EPU_OPC_W-1:0] {
      EPU_NONE    = 3'd0,
      EPU_SYSCALL = 3'd1,
      EPU_RET     = 3'd2,
      EPU_WMSR    = 3'd3,
      EPU_RMSR    = 3'd4
   } epu_opc_t;

   // One-hot, as the serializer only ever waits on one unit
   typedef enum logic [1:0] {
      S_IDLE    = 2'b01,
      S_PENDING = 2'b10
   } cmt_state_t;

   typedef struct packed {
      logic taken;                                      // Predicted taken
      pc_t  tgt;                                        // Predicted target
   } bpu_upd_t;

endpackage
